// File: rtl/acq_pkg.sv
// shared widths, fx bus register map and frame constants
// for the acquisition slave; imported by every RTL block
`default_nettype none

package acq_pkg;

  // bus and data path widths
  typedef logic [15:0] fx_addr_t;
  typedef logic [7:0]  fx_byte_t;
  typedef logic [23:0] sample_t;
  // channel 1 sits in the top 24 bits
  typedef logic [71:0] sample_set_t;

  // module ids, upper address byte
  localparam logic [7:0] MOD_AD1   = 8'h11;
  localparam logic [7:0] MOD_AD2   = 8'h12;
  localparam logic [7:0] MOD_AD3   = 8'h13;
  localparam logic [7:0] MOD_MERGE = 8'h20;
  localparam logic [7:0] MOD_PACK  = 8'h21;

  // register offsets, lower address byte
  localparam logic [7:0] REG_AD_ENABLE   = 8'h00;
  localparam logic [7:0] REG_AD_PERIOD   = 8'h01;
  localparam logic [7:0] REG_AD_COUNT    = 8'h02;
  localparam logic [7:0] REG_MERGE_COUNT = 8'h00;
  localparam logic [7:0] REG_PACK_DEV_ID = 8'h00;
  localparam logic [7:0] REG_PACK_FRAMES = 8'h01;

  // adc timing, in clk_sys and ad_clk cycles
  localparam int AD_CLK_HALF   = 4;
  localparam int AD_MIN_PERIOD = 32;

  // output frame
  localparam logic [7:0] FRAME_HEADER = 8'hA5;
  localparam int         FRAME_LEN    = 13;

  typedef enum logic [2:0] {
    PK_IDLE,
    PK_HEADER,
    PK_DEV_ID,
    PK_SEQ,
    PK_DATA,
    PK_CHECKSUM
  } pack_state_t;

endpackage

`default_nettype wire

// File: rtl/fx_host_port.sv
// host side of the fx register bus: turns host strobes into fx cycles
// and returns the ORed module read data three cycles after host_rd
`default_nettype none

module fx_host_port (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              host_wr,
  input  logic              host_rd,
  input  acq_pkg::fx_addr_t host_addr,
  input  acq_pkg::fx_byte_t host_wdata,
  input  acq_pkg::fx_byte_t fx_q_ad1,
  input  acq_pkg::fx_byte_t fx_q_ad2,
  input  acq_pkg::fx_byte_t fx_q_ad3,
  input  acq_pkg::fx_byte_t fx_q_merge,
  input  acq_pkg::fx_byte_t fx_q_pack,
  output logic              fx_wr,
  output logic              fx_rd,
  output acq_pkg::fx_addr_t fx_waddr,
  output acq_pkg::fx_addr_t fx_raddr,
  output acq_pkg::fx_byte_t fx_data,
  output logic              host_rvld,
  output acq_pkg::fx_byte_t host_rdata
);

  // read in flight, lines up with the module fx_q stage
  logic rd_d1;

  // strobes and read valid pipeline
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_wr     <= 1'b0;
      fx_rd     <= 1'b0;
      rd_d1     <= 1'b0;
      host_rvld <= 1'b0;
    end else begin
      fx_wr     <= host_wr;
      fx_rd     <= host_rd;
      rd_d1     <= fx_rd;
      host_rvld <= rd_d1;
    end
  end

  // address and data hold until the next access
  always_ff @(posedge clk_sys) begin
    if (host_wr) begin
      fx_waddr <= host_addr;
      fx_data  <= host_wdata;
    end
    if (host_rd) begin
      fx_raddr <= host_addr;
    end
  end

  // modules not addressed drive zero, so a plain OR selects
  always_ff @(posedge clk_sys) begin
    host_rdata <= fx_q_ad1 | fx_q_ad2 | fx_q_ad3 | fx_q_merge | fx_q_pack;
  end

endmodule

`default_nettype wire

// File: rtl/ad_channel.sv
// one serial ADC channel: clock and sync generation, 24-bit deserializer
// and the enable, period and sample count registers on the fx bus
`default_nettype none

module ad_channel #(
  parameter logic [7:0] MOD_ID = acq_pkg::MOD_AD1
) (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              ad_din,
  input  logic              fx_wr,
  input  logic              fx_rd,
  input  acq_pkg::fx_addr_t fx_waddr,
  input  acq_pkg::fx_addr_t fx_raddr,
  input  acq_pkg::fx_byte_t fx_data,
  output logic              ad_clk,
  output logic              ad_sync,
  output logic              ad_cfg,
  output logic              ad_vld,
  output acq_pkg::sample_t  ad_data,
  output acq_pkg::fx_byte_t fx_q
);
  import acq_pkg::*;

  logic     enable;
  fx_byte_t period;
  fx_byte_t sample_cnt;
  fx_byte_t half_cnt;
  fx_byte_t per_cnt;
  fx_byte_t per_last;
  logic     half_end;
  logic     rise_evt;
  logic     fall_evt;
  logic     wr_hit;
  logic     shift_done;
  sample_t  shift_sr;

  assign wr_hit = fx_wr && (fx_waddr[15:8] == MOD_ID);

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      enable <= 1'b0;
      period <= 8'(AD_MIN_PERIOD);
    end else if (wr_hit) begin
      case (fx_waddr[7:0])
        REG_AD_ENABLE: enable <= fx_data[0];
        REG_AD_PERIOD: period <= fx_data;
        default: ;
      endcase
    end
  end

  assign ad_cfg = enable;

  // ------------------------------
  // ad_clk divider and period counter
  // ------------------------------
  assign half_end = (half_cnt == 8'(AD_CLK_HALF - 1));
  assign rise_evt = enable && half_end && !ad_clk;
  assign fall_evt = enable && half_end && ad_clk;

  // short periods are stretched to the minimum
  assign per_last = (period < 8'(AD_MIN_PERIOD)) ? 8'(AD_MIN_PERIOD - 1) : period - 8'd1;

  // an ad_clk period is its low phase then its high phase
  always_ff @(posedge clk_sys) begin
    if (reset || !enable) begin
      half_cnt <= '0;
      ad_clk   <= 1'b0;
      per_cnt  <= '0;
    end else begin
      if (half_end) begin
        half_cnt <= '0;
        ad_clk   <= ~ad_clk;
      end else begin
        half_cnt <= half_cnt + 8'd1;
      end
      if (fall_evt) begin
        per_cnt <= (per_cnt >= per_last) ? '0 : per_cnt + 8'd1;
      end
    end
  end

  // first ad_clk period of every sample period
  assign ad_sync = enable && (per_cnt == '0);

  // ------------------------------
  // deserializer
  // ------------------------------
  // periods 1 to 24 carry the bits, MSB first
  always_ff @(posedge clk_sys) begin
    if (rise_evt && (per_cnt != '0) && (per_cnt <= 8'($bits(sample_t)))) begin
      shift_sr <= {shift_sr[$bits(sample_t)-2:0], ad_din};
    end
    if (shift_done) begin
      ad_data <= shift_sr;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      shift_done <= 1'b0;
      ad_vld     <= 1'b0;
      sample_cnt <= '0;
    end else begin
      shift_done <= rise_evt && (per_cnt == 8'($bits(sample_t)));
      ad_vld     <= shift_done;
      // a write to enable restarts the count
      if (wr_hit && (fx_waddr[7:0] == REG_AD_ENABLE)) begin
        sample_cnt <= '0;
      end else if (shift_done) begin
        sample_cnt <= sample_cnt + 8'd1;
      end
    end
  end

  // read back
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_q <= '0;
    end else if (fx_rd && (fx_raddr[15:8] == MOD_ID)) begin
      case (fx_raddr[7:0])
        REG_AD_ENABLE: fx_q <= {7'd0, enable};
        REG_AD_PERIOD: fx_q <= period;
        REG_AD_COUNT:  fx_q <= sample_cnt;
        default:       fx_q <= '0;
      endcase
    end else begin
      fx_q <= '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_merge.sv
// collects one sample from each channel into a sample set,
// counts the sets and exposes the count on the fx bus
`default_nettype none

module sample_merge (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  logic                 ad1_vld,
  input  logic                 ad2_vld,
  input  logic                 ad3_vld,
  input  acq_pkg::sample_t     ad1_data,
  input  acq_pkg::sample_t     ad2_data,
  input  acq_pkg::sample_t     ad3_data,
  input  logic                 fx_rd,
  input  acq_pkg::fx_addr_t    fx_raddr,
  output logic                 set_vld,
  output acq_pkg::sample_set_t set_data,
  output acq_pkg::fx_byte_t    fx_q
);
  import acq_pkg::*;

  logic [2:0] flags;
  logic       all_set;
  sample_t    held1;
  sample_t    held2;
  sample_t    held3;
  fx_byte_t   set_cnt;

  assign all_set = &flags;

  // a new arrival keeps its flag even on the emit cycle
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      flags   <= '0;
      set_vld <= 1'b0;
      set_cnt <= '0;
    end else begin
      flags   <= {ad3_vld, ad2_vld, ad1_vld} | (flags & {3{~all_set}});
      set_vld <= all_set;
      if (all_set) begin
        set_cnt <= set_cnt + 8'd1;
      end
    end
  end

  // latest sample wins
  always_ff @(posedge clk_sys) begin
    if (ad1_vld) held1 <= ad1_data;
    if (ad2_vld) held2 <= ad2_data;
    if (ad3_vld) held3 <= ad3_data;
    if (all_set) set_data <= {held1, held2, held3};
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_q <= '0;
    end else if (fx_rd && (fx_raddr[15:8] == MOD_MERGE)
                 && (fx_raddr[7:0] == REG_MERGE_COUNT)) begin
      fx_q <= set_cnt;
    end else begin
      fx_q <= '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/frame_packer.sv
// packs each sample set into a 13-byte frame with header, dev id,
// sequence number, nine data bytes and an XOR checksum
`default_nettype none

module frame_packer (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  logic                 set_vld,
  input  acq_pkg::sample_set_t set_data,
  input  logic                 fx_wr,
  input  logic                 fx_rd,
  input  acq_pkg::fx_addr_t    fx_waddr,
  input  acq_pkg::fx_addr_t    fx_raddr,
  input  acq_pkg::fx_byte_t    fx_data,
  output acq_pkg::fx_byte_t    pk_data,
  output logic                 pk_vld,
  output logic                 pk_frm,
  output acq_pkg::fx_byte_t    fx_q
);
  import acq_pkg::*;

  pack_state_t state;
  fx_byte_t    dev_id;
  fx_byte_t    frame_cnt;
  fx_byte_t    csum;
  fx_byte_t    byte_cnt;
  sample_set_t data_sr;

  // state names the byte on the output
  assign pk_vld = (state != PK_IDLE);
  assign pk_frm = (state != PK_IDLE);

  always_comb begin
    case (state)
      PK_HEADER:   pk_data = FRAME_HEADER;
      PK_DEV_ID:   pk_data = dev_id;
      PK_SEQ:      pk_data = frame_cnt;
      PK_DATA:     pk_data = data_sr[$bits(sample_set_t)-1 -: 8];
      PK_CHECKSUM: pk_data = csum;
      default:     pk_data = '0;
    endcase
  end

  // ------------------------------
  // frame FSM
  // ------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state     <= PK_IDLE;
      frame_cnt <= '0;
      csum      <= '0;
      byte_cnt  <= '0;
    end else begin
      // running XOR of everything sent so far
      csum <= (state == PK_IDLE) ? '0 : csum ^ pk_data;
      case (state)
        // sets arriving mid-frame are dropped
        PK_IDLE:   if (set_vld) state <= PK_HEADER;
        PK_HEADER: state <= PK_DEV_ID;
        PK_DEV_ID: state <= PK_SEQ;
        PK_SEQ: begin
          state    <= PK_DATA;
          byte_cnt <= '0;
        end
        PK_DATA: begin
          byte_cnt <= byte_cnt + 8'd1;
          // four bytes of the frame are not data
          if (byte_cnt == 8'(FRAME_LEN - 5)) begin
            state <= PK_CHECKSUM;
          end
        end
        PK_CHECKSUM: begin
          state     <= PK_IDLE;
          frame_cnt <= frame_cnt + 8'd1;
        end
        default: state <= PK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if ((state == PK_IDLE) && set_vld) begin
      data_sr <= set_data;
    end else if (state == PK_DATA) begin
      data_sr <= data_sr << 8;
    end
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      dev_id <= '0;
    end else if (fx_wr && (fx_waddr[15:8] == MOD_PACK)
                 && (fx_waddr[7:0] == REG_PACK_DEV_ID)) begin
      dev_id <= fx_data;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_q <= '0;
    end else if (fx_rd && (fx_raddr[15:8] == MOD_PACK)) begin
      case (fx_raddr[7:0])
        REG_PACK_DEV_ID: fx_q <= dev_id;
        REG_PACK_FRAMES: fx_q <= frame_cnt;
        default:         fx_q <= '0;
      endcase
    end else begin
      fx_q <= '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/acq_top.sv
// top of the acquisition slave: host register port, three ADC channels,
// sample merge and frame packer on a shared fx bus
`default_nettype none

module acq_top (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              host_wr,
  input  logic              host_rd,
  input  acq_pkg::fx_addr_t host_addr,
  input  acq_pkg::fx_byte_t host_wdata,
  input  logic              ad1_din,
  input  logic              ad2_din,
  input  logic              ad3_din,
  output logic              host_rvld,
  output acq_pkg::fx_byte_t host_rdata,
  output logic              ad1_clk,
  output logic              ad1_sync,
  output logic              ad1_cfg,
  output logic              ad2_clk,
  output logic              ad2_sync,
  output logic              ad2_cfg,
  output logic              ad3_clk,
  output logic              ad3_sync,
  output logic              ad3_cfg,
  output acq_pkg::fx_byte_t pk_data,
  output logic              pk_vld,
  output logic              pk_frm
);
  import acq_pkg::*;

  // ------------------------------
  // fx bus
  // ------------------------------
  logic     fx_wr;
  logic     fx_rd;
  fx_addr_t fx_waddr;
  fx_addr_t fx_raddr;
  fx_byte_t fx_data;
  fx_byte_t fx_q_ad1;
  fx_byte_t fx_q_ad2;
  fx_byte_t fx_q_ad3;
  fx_byte_t fx_q_merge;
  fx_byte_t fx_q_pack;

  fx_host_port u_host_port (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .fx_q_ad1   (fx_q_ad1),
    .fx_q_ad2   (fx_q_ad2),
    .fx_q_ad3   (fx_q_ad3),
    .fx_q_merge (fx_q_merge),
    .fx_q_pack  (fx_q_pack),
    .fx_wr      (fx_wr),
    .fx_rd      (fx_rd),
    .fx_waddr   (fx_waddr),
    .fx_raddr   (fx_raddr),
    .fx_data    (fx_data),
    .host_rvld  (host_rvld),
    .host_rdata (host_rdata)
  );

  // ------------------------------
  // adc channels
  // ------------------------------
  logic        ad1_vld;
  logic        ad2_vld;
  logic        ad3_vld;
  sample_t     ad1_data;
  sample_t     ad2_data;
  sample_t     ad3_data;

  ad_channel #(.MOD_ID(MOD_AD1)) u_ad1 (
    .clk_sys (clk_sys),
    .reset   (reset),
    .ad_din  (ad1_din),
    .fx_wr   (fx_wr),
    .fx_rd   (fx_rd),
    .fx_waddr(fx_waddr),
    .fx_raddr(fx_raddr),
    .fx_data (fx_data),
    .ad_clk  (ad1_clk),
    .ad_sync (ad1_sync),
    .ad_cfg  (ad1_cfg),
    .ad_vld  (ad1_vld),
    .ad_data (ad1_data),
    .fx_q    (fx_q_ad1)
  );

  ad_channel #(.MOD_ID(MOD_AD2)) u_ad2 (
    .clk_sys (clk_sys),
    .reset   (reset),
    .ad_din  (ad2_din),
    .fx_wr   (fx_wr),
    .fx_rd   (fx_rd),
    .fx_waddr(fx_waddr),
    .fx_raddr(fx_raddr),
    .fx_data (fx_data),
    .ad_clk  (ad2_clk),
    .ad_sync (ad2_sync),
    .ad_cfg  (ad2_cfg),
    .ad_vld  (ad2_vld),
    .ad_data (ad2_data),
    .fx_q    (fx_q_ad2)
  );

  ad_channel #(.MOD_ID(MOD_AD3)) u_ad3 (
    .clk_sys (clk_sys),
    .reset   (reset),
    .ad_din  (ad3_din),
    .fx_wr   (fx_wr),
    .fx_rd   (fx_rd),
    .fx_waddr(fx_waddr),
    .fx_raddr(fx_raddr),
    .fx_data (fx_data),
    .ad_clk  (ad3_clk),
    .ad_sync (ad3_sync),
    .ad_cfg  (ad3_cfg),
    .ad_vld  (ad3_vld),
    .ad_data (ad3_data),
    .fx_q    (fx_q_ad3)
  );

  // ------------------------------
  // merge and pack
  // ------------------------------
  logic        set_vld;
  sample_set_t set_data;

  sample_merge u_merge (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .ad1_vld  (ad1_vld),
    .ad2_vld  (ad2_vld),
    .ad3_vld  (ad3_vld),
    .ad1_data (ad1_data),
    .ad2_data (ad2_data),
    .ad3_data (ad3_data),
    .fx_rd    (fx_rd),
    .fx_raddr (fx_raddr),
    .set_vld  (set_vld),
    .set_data (set_data),
    .fx_q     (fx_q_merge)
  );

  frame_packer u_packer (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .set_vld  (set_vld),
    .set_data (set_data),
    .fx_wr    (fx_wr),
    .fx_rd    (fx_rd),
    .fx_waddr (fx_waddr),
    .fx_raddr (fx_raddr),
    .fx_data  (fx_data),
    .pk_data  (pk_data),
    .pk_vld   (pk_vld),
    .pk_frm   (pk_frm),
    .fx_q     (fx_q_pack)
  );

endmodule

`default_nettype wire

// File: test/acq_top_asserts.sv
// concurrent checks on the acq_top host port, reset state and frame format;
// bound into acq_top together with the testbench sources
`default_nettype none

module acq_top_asserts (
  input logic              clk_sys,
  input logic              reset,
  input logic              host_rd,
  input logic              host_rvld,
  input logic              ad1_clk,
  input logic              ad1_sync,
  input logic              ad2_clk,
  input logic              ad2_sync,
  input logic              ad3_clk,
  input logic              ad3_sync,
  input logic              pk_vld,
  input logic              pk_frm,
  input acq_pkg::fx_byte_t pk_data,
  input acq_pkg::fx_byte_t dev_id
);
  timeunit 1ns;
  timeprecision 1ps;
  import acq_pkg::*;

  int unsigned fail_count = 0;
  logic        quiet;
  fx_byte_t    frame_xor;

  assign quiet = !pk_vld && !pk_frm && !host_rvld
                 && !ad1_clk && !ad1_sync && !ad2_clk && !ad2_sync
                 && !ad3_clk && !ad3_sync;

  // running XOR over the bytes of the current frame
  always_ff @(posedge clk_sys) begin
    if (reset || !pk_frm) begin
      frame_xor <= '0;
    end else begin
      frame_xor <= frame_xor ^ pk_data;
    end
  end

  // ------------------------------
  // host port
  // ------------------------------
  rd_latency: assert property (@(posedge clk_sys) disable iff (reset)
    host_rd |-> ##3 host_rvld)
    else begin fail_count++; $error("host_rvld missing 3 cycles after host_rd"); end

  rvld_source: assert property (@(posedge clk_sys) disable iff (reset)
    host_rvld |-> $past(host_rd, 3))
    else begin fail_count++; $error("host_rvld without a read 3 cycles before"); end

  // outputs idle during reset and on the cycle after it
  reset_quiet: assert property (@(posedge clk_sys)
    reset |=> quiet)
    else begin fail_count++; $error("output active during or right after reset"); end

  // ------------------------------
  // frame format
  // ------------------------------
  frame_length: assert property (@(posedge clk_sys) disable iff (reset)
    $rose(pk_frm) |-> pk_frm [*FRAME_LEN] ##1 !pk_frm)
    else begin fail_count++; $error("pk_frm length differs from FRAME_LEN"); end

  vld_with_frm: assert property (@(posedge clk_sys) disable iff (reset)
    pk_vld == pk_frm)
    else begin fail_count++; $error("pk_vld and pk_frm disagree"); end

  frame_header: assert property (@(posedge clk_sys) disable iff (reset)
    $rose(pk_frm) |-> (pk_data == FRAME_HEADER))
    else begin fail_count++; $error("first frame byte is not the header"); end

  frame_dev_id: assert property (@(posedge clk_sys) disable iff (reset)
    $rose(pk_frm) |=> (pk_data == dev_id))
    else begin fail_count++; $error("second frame byte is not dev_id"); end

  frame_checksum: assert property (@(posedge clk_sys) disable iff (reset)
    $fell(pk_frm) |-> (frame_xor == '0))
    else begin fail_count++; $error("frame bytes do not XOR to zero"); end

endmodule

bind acq_top acq_top_asserts u_asserts (
  .clk_sys   (clk_sys),
  .reset     (reset),
  .host_rd   (host_rd),
  .host_rvld (host_rvld),
  .ad1_clk   (ad1_clk),
  .ad1_sync  (ad1_sync),
  .ad2_clk   (ad2_clk),
  .ad2_sync  (ad2_sync),
  .ad3_clk   (ad3_clk),
  .ad3_sync  (ad3_sync),
  .pk_vld    (pk_vld),
  .pk_frm    (pk_frm),
  .pk_data   (pk_data),
  .dev_id    (u_packer.dev_id)
);

`default_nettype wire

// File: test/acq_top_tb.sv
// testbench for acq_top: serial ADC models, register programming over the
// host port, frame capture and counter readback
`default_nettype none

// shifts a fixed sample out MSB first after each ad_sync
module adc_serial_model (
  input  logic             clk_sys,
  input  logic             ad_clk,
  input  logic             ad_sync,
  input  acq_pkg::sample_t pattern,
  output logic             ad_din
);
  timeunit 1ns;
  timeprecision 1ps;
  import acq_pkg::*;

  logic clk_q;
  logic sync_q;
  int   bit_idx;

  initial begin
    ad_din  = 1'b0;
    clk_q   = 1'b0;
    sync_q  = 1'b0;
    bit_idx = -1;
  end

  always @(posedge clk_sys) begin
    clk_q  <= ad_clk;
    sync_q <= ad_sync;
    // next bit goes out after a falling ad_clk
    if (clk_q && !ad_clk) begin
      if (sync_q && !ad_sync) begin
        ad_din  <= pattern[$bits(sample_t)-1];
        bit_idx <= $bits(sample_t) - 2;
      end else if (bit_idx >= 0) begin
        ad_din  <= pattern[bit_idx];
        bit_idx <= bit_idx - 1;
      end else begin
        ad_din <= 1'b0;
      end
    end
  end

endmodule

module acq_top_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import acq_pkg::*;

  localparam sample_t  PAT_AD1       = 24'h123456;
  localparam sample_t  PAT_AD2       = 24'hABCDEF;
  localparam sample_t  PAT_AD3       = 24'h0F0F0F;
  localparam fx_byte_t DEV_ID        = 8'h5C;
  localparam int       AD_PERIOD     = 40;
  localparam int       SAMPLE_CYCLES = AD_PERIOD * 2 * AD_CLK_HALF;
  localparam int       RD_TIMEOUT    = 16;
  localparam int       NUM_FRAMES    = 4;

  logic     clk_sys;
  logic     reset;
  logic     host_wr;
  logic     host_rd;
  fx_addr_t host_addr;
  fx_byte_t host_wdata;
  logic     ad1_din;
  logic     ad2_din;
  logic     ad3_din;
  logic     host_rvld;
  fx_byte_t host_rdata;
  logic     ad1_clk;
  logic     ad1_sync;
  logic     ad1_cfg;
  logic     ad2_clk;
  logic     ad2_sync;
  logic     ad2_cfg;
  logic     ad3_clk;
  logic     ad3_sync;
  logic     ad3_cfg;
  fx_byte_t pk_data;
  logic     pk_vld;
  logic     pk_frm;
  fx_byte_t frame_buf [FRAME_LEN];

  acq_top acq_top_inst (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .ad1_din    (ad1_din),
    .ad2_din    (ad2_din),
    .ad3_din    (ad3_din),
    .host_rvld  (host_rvld),
    .host_rdata (host_rdata),
    .ad1_clk    (ad1_clk),
    .ad1_sync   (ad1_sync),
    .ad1_cfg    (ad1_cfg),
    .ad2_clk    (ad2_clk),
    .ad2_sync   (ad2_sync),
    .ad2_cfg    (ad2_cfg),
    .ad3_clk    (ad3_clk),
    .ad3_sync   (ad3_sync),
    .ad3_cfg    (ad3_cfg),
    .pk_data    (pk_data),
    .pk_vld     (pk_vld),
    .pk_frm     (pk_frm)
  );

  adc_serial_model ad1_model (
    .clk_sys(clk_sys), .ad_clk(ad1_clk), .ad_sync(ad1_sync), .pattern(PAT_AD1), .ad_din(ad1_din)
  );
  adc_serial_model ad2_model (
    .clk_sys(clk_sys), .ad_clk(ad2_clk), .ad_sync(ad2_sync), .pattern(PAT_AD2), .ad_din(ad2_din)
  );
  adc_serial_model ad3_model (
    .clk_sys(clk_sys), .ad_clk(ad3_clk), .ad_sync(ad3_sync), .pattern(PAT_AD3), .ad_din(ad3_din)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // ------------------------------
  // failure handling
  // ------------------------------
  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic compare_value(input string name, input int unsigned exp_val,
                               input int unsigned act_val);
    assert (act_val == exp_val) else begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // stop at the first concurrent assertion failure
  always @(posedge clk_sys) begin
    if (acq_top_inst.u_asserts.fail_count != 0) begin
      $display("a concurrent assertion inside acq_top failed");
      abort_run();
    end
  end

  // ------------------------------
  // host register access
  // ------------------------------
  task automatic write_reg(input fx_addr_t addr, input fx_byte_t data);
    repeat ($urandom_range(2, 0)) @(posedge clk_sys);
    @(posedge clk_sys);
    host_wr    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clk_sys);
    host_wr <= 1'b0;
  endtask

  task automatic read_reg(input fx_addr_t addr, output fx_byte_t data);
    int wait_cnt;
    repeat ($urandom_range(2, 0)) @(posedge clk_sys);
    @(posedge clk_sys);
    host_rd   <= 1'b1;
    host_addr <= addr;
    @(posedge clk_sys);
    host_rd <= 1'b0;
    wait_cnt = 0;
    while (!host_rvld) begin
      @(posedge clk_sys);
      wait_cnt++;
      if (wait_cnt > RD_TIMEOUT) report_timeout("host_rvld after a read");
    end
    data = host_rdata;
  endtask

  // ------------------------------
  // adc framing and frames
  // ------------------------------
  task automatic measure_adc_framing();
    int   wait_cnt;
    int   sync_len;
    int   rises;
    int   rises_at_vld;
    logic clk_prev;
    wait_cnt = 0;
    while (!ad1_sync) begin
      @(posedge clk_sys);
      wait_cnt++;
      if (wait_cnt > SAMPLE_CYCLES) report_timeout("ad_sync on channel 1");
    end
    sync_len = 0;
    while (ad1_sync) begin
      sync_len++;
      @(posedge clk_sys);
      if (sync_len > SAMPLE_CYCLES) report_timeout("the end of ad_sync on channel 1");
    end
    compare_value("ad_sync length in clk_sys cycles", 2 * AD_CLK_HALF, sync_len);
    rises        = 0;
    rises_at_vld = -1;
    clk_prev     = ad1_clk;
    wait_cnt     = 0;
    while (!ad1_sync) begin
      @(posedge clk_sys);
      wait_cnt++;
      if (!clk_prev && ad1_clk) rises++;
      if (acq_top_inst.u_ad1.ad_vld) rises_at_vld = rises;
      clk_prev = ad1_clk;
      if (wait_cnt > 2 * SAMPLE_CYCLES) report_timeout("the next ad_sync on channel 1");
    end
    compare_value("rising ad_clk edges before ad_vld", $bits(sample_t), rises_at_vld);
    compare_value("rising ad_clk edges between ad_sync", AD_PERIOD - 1, rises);
  endtask

  task automatic capture_frame();
    int wait_cnt;
    int i;
    wait_cnt = 0;
    while (!pk_frm) begin
      @(posedge clk_sys);
      wait_cnt++;
      if (wait_cnt > 4 * SAMPLE_CYCLES) report_timeout("the start of a frame");
    end
    for (i = 0; i < FRAME_LEN; i++) begin
      frame_buf[i] = pk_data;
      @(posedge clk_sys);
    end
  endtask

  task automatic verify_frame(input int idx);
    sample_set_t exp_set;
    int          i;
    exp_set = {PAT_AD1, PAT_AD2, PAT_AD3};
    compare_value($sformatf("frame %0d dev_id byte", idx), DEV_ID, frame_buf[1]);
    compare_value($sformatf("frame %0d sequence number", idx), idx % 256, frame_buf[2]);
    for (i = 0; i < FRAME_LEN - 4; i++) begin
      compare_value($sformatf("frame %0d data byte %0d", idx, i),
                    exp_set[$bits(sample_set_t)-1-8*i -: 8], frame_buf[3+i]);
    end
  endtask

  task automatic observe_disable();
    int i;
    repeat (3) @(posedge clk_sys);
    compare_value("ad_cfg after disabling channel 2", 3'b101, {ad3_cfg, ad2_cfg, ad1_cfg});
    for (i = 0; i < 3 * SAMPLE_CYCLES; i++) begin
      @(posedge clk_sys);
      assert (!ad2_clk) else begin
        $display("ad_clk on channel 2 still runs after it was disabled");
        abort_run();
      end
      assert (!pk_frm) else begin
        $display("a frame appeared after channel 2 was disabled");
        abort_run();
      end
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    fx_byte_t rd_data;
    int       n;
    int       ch;
    void'($urandom(32'h85f1_08c8));
    reset      = 1'b1;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (8) @(posedge clk_sys);
    reset <= 1'b0;

    // register access
    write_reg({MOD_PACK, REG_PACK_DEV_ID}, DEV_ID);
    read_reg({MOD_PACK, REG_PACK_DEV_ID}, rd_data);
    compare_value("dev_id readback", DEV_ID, rd_data);
    read_reg(16'h3000, rd_data);
    compare_value("unmapped read", 0, rd_data);

    // channel 1 alone first, so its framing can be measured
    write_reg({MOD_AD1, REG_AD_PERIOD}, 8'(AD_PERIOD));
    write_reg({MOD_AD2, REG_AD_PERIOD}, 8'(AD_PERIOD));
    write_reg({MOD_AD3, REG_AD_PERIOD}, 8'(AD_PERIOD));
    write_reg({MOD_AD1, REG_AD_ENABLE}, 8'h01);
    measure_adc_framing();
    write_reg({MOD_AD2, REG_AD_ENABLE}, 8'h01);
    write_reg({MOD_AD3, REG_AD_ENABLE}, 8'h01);

    for (n = 0; n < NUM_FRAMES; n++) begin
      capture_frame();
      verify_frame(n);
    end
    compare_value("ad_cfg with all channels enabled", 3'b111, {ad3_cfg, ad2_cfg, ad1_cfg});

    // counters after NUM_FRAMES frames
    read_reg({MOD_PACK, REG_PACK_FRAMES}, rd_data);
    compare_value("packer frame count", NUM_FRAMES, rd_data);
    read_reg({MOD_MERGE, REG_MERGE_COUNT}, rd_data);
    compare_value("merge set count", NUM_FRAMES, rd_data);
    for (ch = 0; ch < 3; ch++) begin
      read_reg({8'(MOD_AD1 + 8'(ch)), REG_AD_COUNT}, rd_data);
      assert (rd_data >= NUM_FRAMES) else begin
        $display("FAILED channel %0d sample count: expected at least %0d, actual %0d",
                 ch + 1, NUM_FRAMES, rd_data);
        abort_run();
      end
    end

    write_reg({MOD_AD2, REG_AD_ENABLE}, 8'h00);
    observe_disable();

    if (acq_top_inst.u_asserts.fail_count != 0) begin
      $display("concurrent assertion failures: %0d", acq_top_inst.u_asserts.fail_count);
      abort_run();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: acq_top.f
rtl/acq_pkg.sv
rtl/fx_host_port.sv
rtl/ad_channel.sv
rtl/sample_merge.sv
rtl/frame_packer.sv
rtl/acq_top.sv
test/acq_top_asserts.sv
test/acq_top_tb.sv

// File: Bender.yml
package:
  name: acq_top

sources:
  - rtl/acq_pkg.sv
  - rtl/fx_host_port.sv
  - rtl/ad_channel.sv
  - rtl/sample_merge.sv
  - rtl/frame_packer.sv
  - rtl/acq_top.sv
  - target: test
    files:
      - test/acq_top_asserts.sv
      - test/acq_top_tb.sv
